// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module sliceGameTb -f sliceGame.f -o simSliceGame \
	&& ./obj_dir/simSliceGame +verilator+error+limit+100 | tee /dev/stderr \
	| grep -q "Verification passed" \
	&& echo "Simulation PASS" \
	|| { echo "Simulation FAIL"; exit 1; }

// ==== sim/sliceGameTb.sv ====
`timescale 1ns/1ps

module sliceGameTb;

	logic clock;
	logic reset;
	logic start;
	slicePkg::point_t pointer;
	logic click;
	slicePkg::objectState_t object;
	logic [slicePkg::ScoreBits-1:0] score;
	logic [6:0] hex0;
	logic [6:0] hex1;
	logic gameOver;

	// Reference model, written only by the compare process
	slicePkg::objectState_t expObject;
	slicePkg::gamePhase_e expPhase;
	logic [7:0] expScore;
	logic [7:0] lfsrX;
	logic [7:0] lfsrSprite;
	logic expHit;
	logic newCut;
	int clicksSeen;
	int respawns;

	int clicksSent;
	logic [31:0] rngState;
	slicePkg::objectState_t heldObject;
	logic [7:0] heldScore;
	int frames;

	sliceGameTop i_dut (
		.clock(clock),
		.reset(reset),
		.start(start),
		.pointer(pointer),
		.click(click),
		.object(object),
		.score(score),
		.hex0(hex0),
		.hex1(hex1),
		.gameOver(gameOver)
	);

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	function automatic logic [7:0] bandStep(input logic [7:0] y);
		if (y >= slicePkg::BandY0)
			return 8'd5;
		else if (y >= slicePkg::BandY1)
			return 8'd4;
		else if (y >= slicePkg::BandY2)
			return 8'd3;
		else if (y >= slicePkg::BandY3)
			return 8'd2;
		else if (y >= slicePkg::BandY4)
			return 8'd1;
		return slicePkg::DefaultStep;
	endfunction

	function automatic slicePkg::objectState_t nextFlight(input slicePkg::objectState_t cur,
		input logic hit, input logic [8:0] spawnX, input slicePkg::sprite_e spawnSprite);
		slicePkg::objectState_t nxt;
		nxt = cur;
		if (!cur.rising && cur.pos.y >= slicePkg::FloorY)
		begin
			nxt.pos.x = spawnX;
			nxt.pos.y = slicePkg::FloorY;
			nxt.rising = 1'b1;
			nxt.cut = 1'b0;
			nxt.sprite = spawnSprite;
			return nxt;
		end
		if (cur.rising && cur.pos.y <= slicePkg::ApexY)
			nxt.rising = 1'b0; // Stalls one frame at the top
		else if (cur.rising)
		begin
			nxt.pos.y = cur.pos.y - bandStep(cur.pos.y);
			nxt.pos.x = cur.pos.x + 9'd1;
		end
		else
		begin
			nxt.pos.y = cur.pos.y + bandStep(cur.pos.y);
			nxt.pos.x = cur.pos.x + 9'd1;
		end
		nxt.cut = cur.cut | hit;
		return nxt;
	endfunction

	function automatic logic [7:0] lfsrNext(input logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
	endfunction

	function automatic logic [6:0] hexPattern(input logic [3:0] n);
		logic [6:0] table16 [16];
		table16 = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
			7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e};
		return table16[n];
	endfunction

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic insideHitBox(input slicePkg::point_t p, input slicePkg::point_t o);
		int dx;
		int dy;
		int r;
		r = int'(slicePkg::HitRadius);
		dx = int'(p.x) - int'(o.x) - int'(slicePkg::HitOffset);
		dy = int'(p.y) - int'(o.y) - int'(slicePkg::HitOffset);
		return (dx > -r) && (dx < r) && (dy > -r) && (dy < r);
	endfunction

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic expectEqual(input string what, input logic [31:0] got, input logic [31:0] want);
		if (got !== want)
			abortRun($sformatf("Fail at %0t ns: %s is %0h, expected %0h", $time, what, got, want));
	endtask

	// Returns 1 ns after the edge that consumes a frame tick
	task automatic waitTick();
		int cycles;
		cycles = 0;
		@(negedge clock);
		while (!i_dut.frameTick)
		begin
			cycles++;
			if (cycles > 2 * slicePkg::FrameTicks)
				abortRun("Timeout: no frame tick within two frame periods");
			@(negedge clock);
		end
		@(posedge clock);
		#1;
	endtask

	task automatic clickAt(input slicePkg::point_t p);
		pointer = p;
		repeat (2) @(posedge clock);
		#1;
		click = 1'b1;
		clicksSent++;
		@(posedge clock);
		#1;
		click = 1'b0;
	endtask

	task automatic clickAway();
		slicePkg::point_t p;
		int dx;
		int dy;
		if (!object.rising && object.pos.y > 8'd200)
			return; // Next flight may spawn under the pointer
		do
		begin
			rngState = xorshift(rngState);
			p.x = rngState[8:0];
			p.y = rngState[16:9];
			dx = int'(p.x) - int'(object.pos.x) - int'(slicePkg::HitOffset);
			dy = int'(p.y) - int'(object.pos.y) - int'(slicePkg::HitOffset);
		end while (dx > -25 && dx < 25 && dy > -25 && dy < 25); // Margin covers one frame of motion
		clickAt(p);
	endtask

	task automatic clickCenter();
		slicePkg::point_t p;
		p.x = object.pos.x + 9'(slicePkg::HitOffset);
		p.y = object.pos.y + slicePkg::HitOffset;
		clickAt(p);
	endtask

	// Compare process
	initial
	begin
		expObject.pos.x = 9'(slicePkg::SeedX >> 1);
		expObject.pos.y = slicePkg::FloorY;
		expObject.rising = 1'b1;
		expObject.cut = 1'b0;
		expObject.sprite = slicePkg::sprite_e'(3'(slicePkg::SeedSprite % 8'd6));
		expPhase = slicePkg::idle;
		expScore = 8'd0;
		lfsrX = slicePkg::SeedX;
		lfsrSprite = slicePkg::SeedSprite;
		expHit = 1'b0;
		clicksSeen = 0;
		respawns = 0;
		forever
		begin
			@(negedge clock);
			if (reset && i_dut.frameTick)
			begin
				newCut = 1'b0;
				if (expPhase == slicePkg::play)
				begin
					if (!expObject.rising && expObject.pos.y >= slicePkg::FloorY)
					begin
						lfsrX = lfsrNext(lfsrX);
						lfsrSprite = lfsrNext(lfsrSprite);
						respawns++;
					end
					else
						newCut = expHit & ~expObject.cut;
					expObject = nextFlight(expObject, expHit, {1'b0, lfsrX[7:1]},
						slicePkg::sprite_e'(3'(lfsrSprite % 8'd6)));
				end
				expHit = (clicksSent != clicksSeen) && insideHitBox(pointer, expObject.pos);
				clicksSeen = clicksSent;
				if (newCut && expObject.sprite == slicePkg::bomb)
					expPhase = slicePkg::over;
				else if (newCut)
					expScore = expScore + 8'd1;
				repeat (3) @(posedge clock); // Object, then score, then hex digits
				@(negedge clock);
				expectEqual("object", 32'(object), 32'(expObject));
				expectEqual("score", 32'(score), 32'(expScore));
				expectEqual("hex0", 32'(hex0), 32'(hexPattern(expScore[3:0])));
				expectEqual("hex1", 32'(hex1), 32'(hexPattern(expScore[7:4])));
				expectEqual("gameOver", 32'(gameOver), 32'(expPhase == slicePkg::over));
				if (expPhase == slicePkg::idle && start)
					expPhase = slicePkg::play;
			end
		end
	end

	// Stimulus
	initial
	begin
		reset = 1'b0;
		start = 1'b0;
		pointer = '0;
		click = 1'b0;
		clicksSent = 0;
		rngState = 32'h3dbdb95c;
		repeat (8) @(posedge clock);
		#1;
		reset = 1'b1;
		@(negedge clock);
		expectEqual("reset object", 32'(object), 32'(expObject));
		expectEqual("reset sprite", 32'(object.sprite), 32'(slicePkg::soldier));
		expectEqual("reset score", 32'(score), 32'd0);
		expectEqual("reset hex0", 32'(hex0), 32'(hexPattern(4'h0)));
		expectEqual("reset hex1", 32'(hex1), 32'(hexPattern(4'h0)));
		expectEqual("reset gameOver", 32'(gameOver), 32'd0);
		heldObject = object;
		repeat (4) waitTick();
		expectEqual("idle object", 32'(object), 32'(heldObject));

		start = 1'b1;
		frames = 0;
		while (respawns < 1)
		begin
			waitTick();
			frames++;
			if (frames > 400)
				abortRun("Timeout: the first flight did not land within 400 frames");
		end

		frames = 0;
		while (respawns < 3)
		begin
			waitTick();
			clickAway();
			frames++;
			if (frames > 800)
				abortRun("Timeout: the missed flights did not end within 800 frames");
		end
		expectEqual("score after misses", 32'(score), 32'd0);

		// Flights 3 to 10 are fruit, flight 11 is the bomb
		frames = 0;
		while (!gameOver)
		begin
			waitTick();
			clickCenter();
			frames++;
			if (frames > 1600)
				abortRun("Timeout: the bomb flight was never sliced within 1600 frames");
		end
		expectEqual("score at bomb", 32'(score), 32'd8);

		heldObject = object;
		heldScore = score;
		repeat (6) waitTick();
		expectEqual("frozen object", 32'(object), 32'(heldObject));
		expectEqual("frozen score", 32'(score), 32'(heldScore));
		expectEqual("gameOver held", 32'(gameOver), 32'd1);

		if (i_dut.i_props.violations == 0)
			$display("Verification passed");
		else
			abortRun($sformatf("Concurrent assertions failed %0d times",
				i_dut.i_props.violations));
		$finish;
	end

endmodule

// ==== sim/sliceGame_props.sv ====
`timescale 1ns/1ps

module sliceGameProps (
	input logic clock,
	input logic reset,
	input logic frameTick,
	input logic playing,
	input logic gameOver,
	input logic [slicePkg::ScoreBits-1:0] score
);

	int violations = 0; // Failure count

	tickSingle: assert property (@(posedge clock) disable iff (!reset) frameTick |=> !frameTick)
	else
	begin
		violations++;
		$error("frameTick high on two consecutive cycles");
	end

	overHeld: assert property (@(posedge clock) disable iff (!reset) $past(gameOver) |-> gameOver)
	else
	begin
		violations++;
		$error("gameOver fell without reset");
	end

	scoreFrozen: assert property (@(posedge clock) disable iff (!reset) !playing |=> $stable(score))
	else
	begin
		violations++;
		$error("score changed outside play");
	end

endmodule

bind sliceGameTop sliceGameProps i_props (
	.clock(clock),
	.reset(reset),
	.frameTick(frameTick),
	.playing(playing),
	.gameOver(gameOver),
	.score(score)
);

// ==== sliceGame.f ====
src/slicePkg.sv
src/frameTicker.sv
src/pointerLatch.sv
src/randomSource.sv
src/flightPath.sv
src/sliceDetector.sv
src/gameControl.sv
src/scoreDisplay.sv
src/sliceGameTop.sv
sim/sliceGame_props.sv
sim/sliceGameTb.sv

// ==== src/flightPath.sv ====
`timescale 1ns/1ps

module flightPath (
	input logic clock,
	input logic reset,
	input logic frameTick,
	input logic playing,
	input logic hit,
	input logic [8:0] spawnX,
	input slicePkg::sprite_e spawnSprite,
	output slicePkg::objectState_t object,
	output logic respawn,
	output logic newCut
);

	logic [7:0] step;
	logic landed;

	// First band whose threshold y reaches
	function automatic logic [7:0] bandStep(input logic [7:0] y);
		if (y >= slicePkg::BandY0)
			return slicePkg::BandStep0;
		else if (y >= slicePkg::BandY1)
			return slicePkg::BandStep1;
		else if (y >= slicePkg::BandY2)
			return slicePkg::BandStep2;
		else if (y >= slicePkg::BandY3)
			return slicePkg::BandStep3;
		else if (y >= slicePkg::BandY4)
			return slicePkg::BandStep4;
		else
			return slicePkg::DefaultStep;
	endfunction

	assign step = bandStep(object.pos.y);
	assign landed = !object.rising && (object.pos.y >= slicePkg::FloorY);

	always_ff @(posedge clock)
	begin
		if (!reset)
		begin
			object.pos.x <= 9'(slicePkg::SeedX >> 1);
			object.pos.y <= slicePkg::FloorY;
			object.rising <= 1'b1;
			object.cut <= 1'b0;
			object.sprite <= slicePkg::sprite_e'(3'(slicePkg::SeedSprite % 8'd6));
			respawn <= 1'b0;
			newCut <= 1'b0;
		end
		else
		begin
			respawn <= 1'b0;
			newCut <= 1'b0;
			if (frameTick && playing)
			begin
				if (landed)
				begin
					// New flight from the floor
					object.pos.x <= spawnX;
					object.pos.y <= slicePkg::FloorY;
					object.rising <= 1'b1;
					object.cut <= 1'b0;
					object.sprite <= spawnSprite;
					respawn <= 1'b1;
				end
				else
				begin
					object.cut <= object.cut | hit;
					newCut <= hit & ~object.cut; // Only the first cut of a flight
					if (object.rising)
					begin
						if (object.pos.y <= slicePkg::ApexY)
						begin
							object.rising <= 1'b0; // Hang one frame at the apex
						end
						else
						begin
							object.pos.y <= object.pos.y - step;
							object.pos.x <= object.pos.x + 9'd1;
						end
					end
					else
					begin
						object.pos.y <= object.pos.y + step;
						object.pos.x <= object.pos.x + 9'd1;
					end
				end
			end
		end
	end

endmodule

// ==== src/frameTicker.sv ====
`timescale 1ns/1ps

module frameTicker (
	input logic clock,
	input logic reset,
	output logic frameTick
);

	logic [slicePkg::FrameCountBits-1:0] count;

	always_ff @(posedge clock)
	begin
		if (!reset)
		begin
			count <= slicePkg::FrameCountBits'(slicePkg::FrameTicks - 1);
			frameTick <= 1'b0;
		end
		else if (count == '0)
		begin
			count <= slicePkg::FrameCountBits'(slicePkg::FrameTicks - 1); // Reload
			frameTick <= 1'b1;
		end
		else
		begin
			count <= count - 1'b1;
			frameTick <= 1'b0;
		end
	end

endmodule

// ==== src/gameControl.sv ====
`timescale 1ns/1ps

module gameControl (
	input logic clock,
	input logic reset,
	input logic start,
	input logic newCut,
	input slicePkg::sprite_e sprite,
	output logic playing,
	output logic gameOver,
	output logic [slicePkg::ScoreBits-1:0] score
);

	slicePkg::gamePhase_e phase;

	always_ff @(posedge clock)
	begin
		if (!reset)
		begin
			phase <= slicePkg::idle;
			score <= '0;
		end
		else
		begin
			case (phase)
				slicePkg::idle:
					if (start)
						phase <= slicePkg::play;
				slicePkg::play:
					if (newCut)
					begin
						if (sprite == slicePkg::bomb)
							phase <= slicePkg::over; // Bomb scores nothing
						else
							score <= score + 1'b1;
					end
				slicePkg::over:
					phase <= slicePkg::over; // Held until reset
				default:
					phase <= slicePkg::idle;
			endcase
		end
	end

	assign playing = (phase == slicePkg::play);
	assign gameOver = (phase == slicePkg::over);

endmodule

// ==== src/pointerLatch.sv ====
`timescale 1ns/1ps

module pointerLatch (
	input logic clock,
	input logic reset,
	input logic frameTick,
	input logic click,
	input slicePkg::point_t pointer,
	output slicePkg::pointerEvent_t pointerEvent
);

	logic clickSeen; // Sticky until the next tick

	always_ff @(posedge clock)
	begin
		if (!reset)
		begin
			clickSeen <= 1'b0;
			pointerEvent <= '0;
		end
		else if (frameTick)
		begin
			// A click in the tick cycle itself still counts for this frame
			pointerEvent.pos <= pointer;
			pointerEvent.click <= clickSeen | click;
			clickSeen <= 1'b0;
		end
		else if (click)
		begin
			clickSeen <= 1'b1;
		end
	end

endmodule

// ==== src/randomSource.sv ====
`timescale 1ns/1ps

module randomSource (
	input logic clock,
	input logic reset,
	input logic respawn,
	output logic [8:0] spawnX,
	output slicePkg::sprite_e spawnSprite
);

	logic [7:0] lfsrX;
	logic [7:0] lfsrSprite;
	logic [7:0] nextX;
	logic [7:0] nextSprite;

	// Fibonacci taps 7 5 4 3, new bit enters at the bottom
	function automatic logic [7:0] lfsrStep(input logic [7:0] state);
		return {state[6:0], state[7] ^ state[5] ^ state[4] ^ state[3]};
	endfunction

	assign nextX = lfsrStep(lfsrX);
	assign nextSprite = lfsrStep(lfsrSprite);

	assign spawnX = {1'b0, nextX[7:1]}; // Column is state / 2
	assign spawnSprite = slicePkg::sprite_e'(3'(nextSprite % 8'd6));

	always_ff @(posedge clock)
	begin
		if (!reset)
		begin
			lfsrX <= slicePkg::SeedX;
			lfsrSprite <= slicePkg::SeedSprite;
		end
		else if (respawn)
		begin
			lfsrX <= nextX;
			lfsrSprite <= nextSprite;
		end
	end

endmodule

// ==== src/scoreDisplay.sv ====
`timescale 1ns/1ps

module scoreDisplay (
	input logic clock,
	input logic reset,
	input logic [slicePkg::ScoreBits-1:0] score,
	output logic [6:0] hex0,
	output logic [6:0] hex1
);

	// Active low, bit order gfedcba
	function automatic logic [6:0] hexSegments(input logic [3:0] nibble);
		case (nibble)
			4'h0: return 7'b1000000;
			4'h1: return 7'b1111001;
			4'h2: return 7'b0100100;
			4'h3: return 7'b0110000;
			4'h4: return 7'b0011001;
			4'h5: return 7'b0010010;
			4'h6: return 7'b0000010;
			4'h7: return 7'b1111000;
			4'h8: return 7'b0000000;
			4'h9: return 7'b0010000;
			4'ha: return 7'b0001000;
			4'hb: return 7'b0000011;
			4'hc: return 7'b1000110;
			4'hd: return 7'b0100001;
			4'he: return 7'b0000110;
			default: return 7'b0001110; // F
		endcase
	endfunction

	always_ff @(posedge clock)
	begin
		if (!reset)
		begin
			hex0 <= hexSegments(4'h0);
			hex1 <= hexSegments(4'h0);
		end
		else
		begin
			hex0 <= hexSegments(score[3:0]);
			hex1 <= hexSegments(score[7:4]); // High nibble
		end
	end

endmodule

// ==== src/sliceDetector.sv ====
`timescale 1ns/1ps

module sliceDetector (
	input logic clock,
	input logic reset,
	input slicePkg::pointerEvent_t pointerEvent,
	input slicePkg::point_t objectPos,
	output logic hit
);

	logic [9:0] centerX;
	logic [8:0] centerY;
	logic [9:0] pointX;
	logic [8:0] pointY;
	logic inX;
	logic inY;

	// One extra bit so the sums near the floor do not wrap
	assign centerX = {1'b0, objectPos.x} + 10'(slicePkg::HitOffset);
	assign centerY = {1'b0, objectPos.y} + 9'(slicePkg::HitOffset);
	assign pointX = {1'b0, pointerEvent.pos.x};
	assign pointY = {1'b0, pointerEvent.pos.y};

	// |p - c| < r on each axis, kept unsigned
	assign inX = (pointX + 10'(slicePkg::HitRadius) > centerX) &&
		(pointX < centerX + 10'(slicePkg::HitRadius));
	assign inY = (pointY + 9'(slicePkg::HitRadius) > centerY) &&
		(pointY < centerY + 9'(slicePkg::HitRadius));

	always_ff @(posedge clock)
	begin
		if (!reset)
			hit <= 1'b0;
		else
			hit <= pointerEvent.click & inX & inY;
	end

endmodule

// ==== src/sliceGameTop.sv ====
`timescale 1ns/1ps

module sliceGameTop (
	input logic clock,
	input logic reset,
	input logic start,
	input slicePkg::point_t pointer,
	input logic click,
	output slicePkg::objectState_t object,
	output logic [slicePkg::ScoreBits-1:0] score,
	output logic [6:0] hex0,
	output logic [6:0] hex1,
	output logic gameOver
);

	logic frameTick;
	slicePkg::pointerEvent_t pointerEvent;
	logic [8:0] spawnX;
	slicePkg::sprite_e spawnSprite;
	logic respawn;
	logic hit;
	logic newCut;
	logic playing;

	// Input side
	frameTicker i_frameTicker (
		.clock(clock),
		.reset(reset),
		.frameTick(frameTick)
	);

	pointerLatch i_pointerLatch (
		.clock(clock),
		.reset(reset),
		.frameTick(frameTick),
		.click(click),
		.pointer(pointer),
		.pointerEvent(pointerEvent)
	);

	randomSource i_randomSource (
		.clock(clock),
		.reset(reset),
		.respawn(respawn),
		.spawnX(spawnX),
		.spawnSprite(spawnSprite)
	);

	flightPath i_flightPath (
		.clock(clock),
		.reset(reset),
		.frameTick(frameTick),
		.playing(playing),
		.hit(hit),
		.spawnX(spawnX),
		.spawnSprite(spawnSprite),
		.object(object),
		.respawn(respawn),
		.newCut(newCut)
	);

	sliceDetector i_sliceDetector (
		.clock(clock),
		.reset(reset),
		.pointerEvent(pointerEvent),
		.objectPos(object.pos),
		.hit(hit)
	);

	gameControl i_gameControl (
		.clock(clock),
		.reset(reset),
		.start(start),
		.newCut(newCut),
		.sprite(object.sprite),
		.playing(playing),
		.gameOver(gameOver),
		.score(score)
	);

	// Output side
	scoreDisplay i_scoreDisplay (
		.clock(clock),
		.reset(reset),
		.score(score),
		.hex0(hex0),
		.hex1(hex1)
	);

endmodule

// ==== src/slicePkg.sv ====
package slicePkg;

	localparam int FrameTicks = 16; // Clocks per frame, short for simulation
	localparam int FrameCountBits = $clog2(FrameTicks);

	// Screen rows, y grows downward
	localparam logic [7:0] FloorY = 8'd240;
	localparam logic [7:0] ApexY = 8'd60;

	// Speed bands, slower near the apex
	localparam logic [7:0] BandY0 = 8'd180;
	localparam logic [7:0] BandY1 = 8'd132;
	localparam logic [7:0] BandY2 = 8'd96;
	localparam logic [7:0] BandY3 = 8'd72;
	localparam logic [7:0] BandY4 = 8'd60;
	localparam logic [7:0] BandStep0 = 8'd5;
	localparam logic [7:0] BandStep1 = 8'd4;
	localparam logic [7:0] BandStep2 = 8'd3;
	localparam logic [7:0] BandStep3 = 8'd2;
	localparam logic [7:0] BandStep4 = 8'd1;
	localparam logic [7:0] DefaultStep = 8'd3;

	localparam logic [7:0] HitOffset = 8'd15; // Sprite corner to center
	localparam logic [7:0] HitRadius = 8'd15;

	localparam logic [7:0] SeedX = 8'b00111001;
	localparam logic [7:0] SeedSprite = 8'b11101001;

	localparam int ScoreBits = 8;

	typedef struct packed {
		logic [8:0] x;
		logic [7:0] y;
	} point_t;

	typedef struct packed {
		point_t pos;
		logic click;
	} pointerEvent_t;

	typedef enum logic [2:0] {
		jet = 3'd0,
		lord = 3'd1,
		bomb = 3'd2,
		robot = 3'd3,
		hunter = 3'd4,
		soldier = 3'd5
	} sprite_e;

	typedef enum logic [1:0] {
		idle,
		play,
		over
	} gamePhase_e;

	typedef struct packed {
		point_t pos;
		logic rising;
		logic cut;
		sprite_e sprite;
	} objectState_t;

endpackage
